/* rtl/ps2_defs.svh */
`ifndef PS2_DEFS_SVH
`define PS2_DEFS_SVH

// ==================================================
// timing constants
// ==================================================

// system clock rate in hz
`define PS2_CLK_FREQ 125000000

// one-shot limits in system clock cycles
`define PS2_CNT_5US (`PS2_CLK_FREQ / 200000)
`define PS2_CNT_100US (`PS2_CLK_FREQ / 10000)

// ==================================================
// line filter geometry
// ==================================================

// device clock delay line length and the stage used for edges
`define PS2_CLK_DEPTH 16
`define PS2_CLK_TAP 10

// data samples taken into the majority vote
`define PS2_MAJ_DEPTH 7

`endif

/* rtl/ps2_pkg.sv */
package ps2_pkg;

	// register select, one address bit
	typedef enum logic {
		REG_DATA   = 1'b0,
		REG_STATUS = 1'b1
	} ps2_reg_addr_e;

	// register request as seen on the bus side
	typedef struct packed {
		logic          cs;
		logic          we;
		ps2_reg_addr_e adr;
		logic [7:0]    dat;
	} ps2_bus_req_t;

	// filtered view of the device lines
	typedef struct packed {
		logic clk;
		logic clk_fall;
		logic clk_rise;
		logic dat;
	} ps2_line_t;

	// receive side summary
	typedef struct packed {
		logic       full;
		logic       perr;
		logic [7:0] data;
	} ps2_rx_stat_t;

	// status register layout, msb first
	typedef struct packed {
		logic       rx_full;
		logic       tc;
		logic       ack;
		logic [3:0] rsvd;
		logic       perr;
	} ps2_status_t;

	// one read word, either the byte or the status bits
	typedef union packed {
		logic [7:0]  data;
		ps2_status_t status;
	} ps2_reg_word_u;

endpackage

/* rtl/ps2_line_filter.sv */
`timescale 1ns/10ps

`include "ps2_defs.svh"

module ps2_line_filter (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               kclk_i,
	input  logic               kdat_i,
	output ps2_pkg::ps2_line_t line_o
);

	// raw delay lines, newest sample in bit 0
	logic [`PS2_CLK_DEPTH-1:0] kclk_q;
	logic [`PS2_MAJ_DEPTH-1:0] kdat_q;
	// previous value of the tapped clock stage
	logic                      clk_tap_d;
	// number of high data samples
	logic [2:0]                ones;

	// ==================================================
	// delay lines
	// ==================================================

	// lines idle high, so preset to ones to avoid a false edge
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			kclk_q    <= '1;
			kdat_q    <= '1;
			clk_tap_d <= 1'b1;
		end else begin
			kclk_q    <= {kclk_q[`PS2_CLK_DEPTH-2:0], kclk_i};
			kdat_q    <= {kdat_q[`PS2_MAJ_DEPTH-2:0], kdat_i};
			clk_tap_d <= kclk_q[`PS2_CLK_TAP];
		end
	end

	// ==================================================
	// majority vote and edge detect
	// ==================================================

	// count the ones in the data window
	always_comb begin
		ones = '0;
		for (int i = 0; i < `PS2_MAJ_DEPTH; i++) begin
			ones = ones + 3'(kdat_q[i]);
		end
	end

	// more than half high gives a high data level
	assign line_o.dat      = (ones > 3'(`PS2_MAJ_DEPTH / 2));
	assign line_o.clk      = kclk_q[`PS2_CLK_TAP];
	// edges on the tapped stage only
	assign line_o.clk_fall = clk_tap_d & ~kclk_q[`PS2_CLK_TAP];
	assign line_o.clk_rise = ~clk_tap_d & kclk_q[`PS2_CLK_TAP];

endmodule

/* rtl/ps2_timer.sv */
`timescale 1ns/10ps

`include "ps2_defs.svh"

module ps2_timer (
	input  logic clk_i,
	input  logic rst_i,
	input  logic rx_restart_i,
	input  logic tx_restart_i,
	output logic done_5us_o,
	output logic done_100us_o
);

	// cycles since the last restart
	logic [13:0] cnt;

	// shared one-shot
	// either side may restart it, they never run at the same time
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt <= '0;
		end else if (rx_restart_i || tx_restart_i) begin
			cnt <= '0;
		end else if (cnt != 14'(`PS2_CNT_100US + 1)) begin
			// stop one past the long limit so its flag is a single cycle
			cnt <= cnt + 14'd1;
		end
	end

	// each flag is true on one cycle only
	assign done_5us_o   = (cnt == 14'(`PS2_CNT_5US));
	assign done_100us_o = (cnt == 14'(`PS2_CNT_100US));

endmodule

/* rtl/ps2_rx_frame.sv */
`timescale 1ns/10ps

module ps2_rx_frame (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  ps2_pkg::ps2_line_t    line_i,
	input  logic                  done_5us_i,
	input  logic                  inhibit_i,
	input  logic                  clear_i,
	output logic                  restart_o,
	output ps2_pkg::ps2_rx_stat_t stat_o
);

	typedef enum logic [1:0] {
		RX_WAIT_FALL = 2'd0,
		RX_CHECK_LOW = 2'd1,
		RX_CAPTURE   = 2'd2
	} rx_state_e;

	rx_state_e   state;
	// frame shift register, start bit ends up in bit 0
	logic [10:0] shreg;

	// ==================================================
	// receive fsm
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= RX_WAIT_FALL;
			shreg <= '1;
		end else begin
			// status write of 00 empties the register
			if (clear_i) begin
				shreg <= '1;
			end
			case (state)
				// falling clock starts the debounce
				RX_WAIT_FALL: begin
					if (line_i.clk_fall && !inhibit_i) begin
						state <= RX_CHECK_LOW;
					end
				end
				// clock must still be low after 5 us
				RX_CHECK_LOW: begin
					if (inhibit_i) begin
						state <= RX_WAIT_FALL;
					end else if (done_5us_i) begin
						// high again means a glitch, drop it
						state <= line_i.clk ? RX_WAIT_FALL : RX_CAPTURE;
					end
				end
				// lsb first, so shift in from the top
				RX_CAPTURE: begin
					shreg <= {line_i.dat, shreg[10:1]};
					state <= RX_WAIT_FALL;
				end
				default: begin
					state <= RX_WAIT_FALL;
				end
			endcase
		end
	end

	// debounce count starts at the edge, stops when the host takes over
	assign restart_o = (state == RX_WAIT_FALL && line_i.clk_fall && !inhibit_i) ||
		(state == RX_CHECK_LOW && inhibit_i);

	// zero start bit in bit 0 marks a whole frame
	assign stat_o.full = ~shreg[0];
	// data plus parity should hold an odd number of ones
	assign stat_o.perr = ~^shreg[9:1];
	assign stat_o.data = shreg[8:1];

endmodule

/* rtl/ps2_tx_sequencer.sv */
`timescale 1ns/10ps

module ps2_tx_sequencer (
	input  logic               clk_i,
	input  logic               rst_i,
	input  ps2_pkg::ps2_line_t line_i,
	input  logic               done_5us_i,
	input  logic               done_100us_i,
	input  logic               load_i,
	input  logic               abort_i,
	input  logic               shift_done_i,
	input  logic               rx_full_i,
	output logic               restart_o,
	output logic               shift_o,
	output logic               oe_o,
	output logic               kclk_en_o,
	output logic               tc_o,
	output logic               ack_o,
	output logic               busy_o
);

	// one-hot step register, all zero when idle
	logic [16:0] step;
	// current step has met its condition
	logic        advance;
	// host pulls the clock low
	logic        clk_low;

	// ==================================================
	// step advance conditions
	// ==================================================

	always_comb begin
		case (1'b1)
			step[0]:  advance = 1'b1;
			// clock held low for 100 us
			step[1]:  advance = done_100us_i;
			step[2]:  advance = 1'b1;
			step[3]:  advance = done_5us_i;
			step[4]:  advance = 1'b1;
			// device takes over the clock
			step[5]:  advance = line_i.clk_fall;
			step[6]:  advance = done_5us_i;
			// data bits leave on rising edges
			step[7]:  advance = line_i.clk_rise;
			step[8]:  advance = done_5us_i;
			step[9]:  advance = line_i.clk_rise;
			step[10]: advance = done_5us_i;
			// device pulls data low for the acknowledge
			step[11]: advance = line_i.clk_fall;
			step[12]: advance = done_5us_i;
			step[13]: advance = 1'b1;
			step[14]: advance = line_i.clk_rise;
			step[15]: advance = done_5us_i;
			default:  advance = 1'b0;
		endcase
	end

	// ==================================================
	// step register and line controls
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			step    <= '0;
			clk_low <= 1'b0;
			oe_o    <= 1'b0;
			tc_o    <= 1'b1;
			ack_o   <= 1'b0;
		end else if (abort_i) begin
			// status write of FF drops everything
			step    <= '0;
			clk_low <= 1'b0;
			oe_o    <= 1'b0;
			tc_o    <= 1'b1;
		end else if (load_i) begin
			step  <= 17'd1;
			oe_o  <= 1'b0;
			tc_o  <= 1'b0;
			ack_o <= 1'b0;
		end else begin
			if (step[0]) begin
				clk_low <= 1'b1;
			end
			// start bit goes out while the clock is still low
			if (step[2]) begin
				oe_o <= 1'b1;
			end
			if (step[4]) begin
				clk_low <= 1'b0;
			end
			if (step[9]) begin
				oe_o <= 1'b0;
			end
			// low data here is the acknowledge
			if (step[13]) begin
				ack_o <= ~line_i.dat;
			end
			if (step[16]) begin
				step <= '0;
				tc_o <= 1'b1;
			end else if (advance) begin
				step[6:0]   <= {step[5:0], 1'b0};
				// loop over 7 and 8 until the shifter runs out
				step[7]     <= step[6] | (step[8] & ~shift_done_i);
				step[8]     <= step[7];
				step[9]     <= step[8] & shift_done_i;
				step[16:10] <= step[15:9];
			end
		end
	end

	// timer restarts ahead of every timed or edge-waiting step
	assign restart_o = step[0] | step[2] | step[5] | step[7] | step[9] |
		step[11] | step[14];
	// one shift to line up the start bit, then one per rising edge
	assign shift_o   = step[4] | (step[7] & line_i.clk_rise);
	// an unread byte also holds the clock low
	assign kclk_en_o = clk_low | rx_full_i;
	assign busy_o    = |step;

	assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(step))
		else $error("ps2_tx_sequencer: step register not one-hot");

endmodule

/* rtl/ps2_tx_shifter.sv */
`timescale 1ns/10ps

module ps2_tx_shifter (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       load_i,
	input  logic [7:0] byte_i,
	input  logic       shift_i,
	input  logic       oe_i,
	output logic       kdat_en_o,
	output logic       done_o
);

	// {parity, data, start, pad}, bit 0 is on the line
	logic [10:0] sreg;
	// bits still to go
	logic [3:0]  cnt;

	// odd parity over the byte, ones shifted in become the stop bit
	always_ff @(posedge clk_i) begin
		if (load_i) begin
			sreg <= {~^byte_i, byte_i, 2'b00};
		end else if (shift_i) begin
			sreg <= {1'b1, sreg[10:1]};
		end
	end

	// bit counter
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt <= '0;
		end else if (load_i) begin
			cnt <= 4'd11;
		end else if (shift_i) begin
			cnt <= cnt - 4'd1;
		end
	end

	// pull data low only for a zero bit
	assign kdat_en_o = oe_i & ~sreg[0];
	assign done_o    = (cnt == 4'd0);

	// sequencer must stop shifting once the count runs out
	assert property (@(posedge clk_i) disable iff (rst_i) shift_i |-> (cnt != 4'd0))
		else $error("ps2_tx_shifter: shift with empty counter");

endmodule

/* rtl/ps2_regs.sv */
`timescale 1ns/10ps

module ps2_regs (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  ps2_pkg::ps2_bus_req_t req_i,
	input  ps2_pkg::ps2_rx_stat_t rx_i,
	input  logic                  tc_i,
	input  logic                  ack_i,
	output logic [7:0]            dat_o,
	output logic                  ack_o,
	output logic                  load_tx_o,
	output logic [7:0]            byte_o,
	output logic                  clear_rx_o,
	output logic                  abort_tx_o
);
	import ps2_pkg::*;

	logic          cs_q;
	ps2_reg_addr_e adr_q;
	logic          wr_status;
	ps2_reg_word_u rd_word;

	// ==================================================
	// write decode
	// ==================================================

	// commands act on the edge that registers the request
	assign load_tx_o  = req_i.cs & req_i.we & (req_i.adr == REG_DATA);
	assign byte_o     = req_i.dat;
	assign wr_status  = req_i.cs & req_i.we & (req_i.adr == REG_STATUS);
	assign clear_rx_o = wr_status & (req_i.dat == 8'h00);
	assign abort_tx_o = wr_status & (req_i.dat == 8'hFF);

	// ==================================================
	// read path
	// ==================================================

	always_comb begin
		rd_word = '0;
		if (adr_q == REG_DATA) begin
			rd_word.data = rx_i.data;
		end else begin
			rd_word.status.rx_full = rx_i.full;
			rd_word.status.tc      = tc_i;
			rd_word.status.ack     = ack_i;
			rd_word.status.perr    = rx_i.perr;
		end
	end

	// request stage then response stage, two edges in all
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cs_q  <= 1'b0;
			ack_o <= 1'b0;
		end else begin
			cs_q  <= req_i.cs;
			ack_o <= cs_q;
		end
	end

	// idle bus reads as zero
	always_ff @(posedge clk_i) begin
		adr_q <= req_i.adr;
		dat_o <= cs_q ? rd_word.data : 8'h00;
	end

endmodule

/* rtl/ps2_host.sv */
`timescale 1ns/10ps

module ps2_host (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  ps2_pkg::ps2_bus_req_t req_i,
	output logic [7:0]            dat_o,
	output logic                  ack_o,
	output logic                  irq_o,
	input  logic                  kclk_i,
	input  logic                  kdat_i,
	output logic                  kclk_en_o,
	output logic                  kdat_en_o
);
	import ps2_pkg::*;

	ps2_line_t    line;
	ps2_rx_stat_t rx_stat;
	logic         done_5us;
	logic         done_100us;
	logic         rx_restart;
	logic         tx_restart;
	// register commands
	logic         load_tx;
	logic [7:0]   tx_byte;
	logic         clear_rx;
	logic         abort_tx;
	// transmitter handshakes
	logic         tx_shift;
	logic         tx_oe;
	logic         shift_done;
	logic         tc;
	logic         tx_ack;
	logic         tx_busy;

	// ==================================================
	// device side
	// ==================================================

	ps2_line_filter i_line_filter (
		.clk_i (clk_i), .rst_i (rst_i), .kclk_i (kclk_i), .kdat_i (kdat_i), .line_o (line)
	);

	ps2_timer i_timer (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.rx_restart_i (rx_restart),
		.tx_restart_i (tx_restart),
		.done_5us_o   (done_5us),
		.done_100us_o (done_100us)
	);

	// receiver stays idle while the host owns the lines
	ps2_rx_frame i_rx_frame (
		.clk_i (clk_i), .rst_i (rst_i), .line_i (line), .done_5us_i (done_5us),
		.inhibit_i (tx_busy), .clear_i (clear_rx), .restart_o (rx_restart), .stat_o (rx_stat)
	);

	ps2_tx_sequencer i_tx_sequencer (
		.clk_i (clk_i), .rst_i (rst_i), .line_i (line), .done_5us_i (done_5us),
		.done_100us_i (done_100us), .load_i (load_tx), .abort_i (abort_tx),
		.shift_done_i (shift_done), .rx_full_i (rx_stat.full), .restart_o (tx_restart),
		.shift_o (tx_shift), .oe_o (tx_oe), .kclk_en_o (kclk_en_o), .tc_o (tc),
		.ack_o (tx_ack), .busy_o (tx_busy)
	);

	ps2_tx_shifter i_tx_shifter (
		.clk_i (clk_i), .rst_i (rst_i), .load_i (load_tx), .byte_i (tx_byte),
		.shift_i (tx_shift), .oe_i (tx_oe), .kdat_en_o (kdat_en_o), .done_o (shift_done)
	);

	// ==================================================
	// register side
	// ==================================================

	ps2_regs i_regs (
		.clk_i (clk_i), .rst_i (rst_i), .req_i (req_i), .rx_i (rx_stat), .tc_i (tc),
		.ack_i (tx_ack), .dat_o (dat_o), .ack_o (ack_o), .load_tx_o (load_tx),
		.byte_o (tx_byte), .clear_rx_o (clear_rx), .abort_tx_o (abort_tx)
	);

	// interrupt while a byte waits to be read
	assign irq_o = rx_stat.full;

endmodule

/* test/ps2_dev_model.sv */
`timescale 1ns/10ps

`include "ps2_defs.svh"

module ps2_dev_model (
	input  logic clk_i,
	input  logic kclk_i,
	input  logic kdat_i,
	output logic kclk_pull_o,
	output logic kdat_pull_o
);

	// device clock of 40 us, counted in system clock cycles
	localparam int HALF_CYC    = `PS2_CLK_FREQ / 50000;
	localparam int QUARTER_CYC = HALF_CYC / 2;
	// well below the 5 us debounce
	localparam int GLITCH_CYC  = `PS2_CNT_5US * 2 / 5;

	// both lines released at start
	initial begin
		kclk_pull_o = 1'b0;
		kdat_pull_o = 1'b0;
	end

	// line changes always land on falling host clock edges
	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_i);
	endtask

	// low half then release
	task automatic clock_pulse();
		kclk_pull_o = 1'b1;
		wait_cycles(HALF_CYC);
		kclk_pull_o = 1'b0;
	endtask

	// ==================================================
	// device to host
	// ==================================================

	task automatic send_frame(input logic [7:0] val, input logic bad_parity);
		logic [10:0] frame;
		// stop, parity, data, start, lsb goes first
		frame = {1'b1, (~^val) ^ bad_parity, val, 1'b0};
		// host may still inhibit the device
		while (!kclk_i) @(negedge clk_i);
		wait_cycles(QUARTER_CYC);
		for (int i = 0; i < 11; i++) begin
			// data set up a quarter period before the fall
			kdat_pull_o = ~frame[i];
			wait_cycles(QUARTER_CYC);
			clock_pulse();
			wait_cycles(QUARTER_CYC);
		end
		kdat_pull_o = 1'b0;
	endtask

	// short low pulse on the clock only
	task automatic send_glitch();
		// data low throughout, so a glitch taken as a bit leaves a zero behind
		kdat_pull_o = 1'b1;
		kclk_pull_o = 1'b1;
		wait_cycles(GLITCH_CYC);
		kclk_pull_o = 1'b0;
		// receiver needs its debounce time to drop it
		wait_cycles(HALF_CYC);
		kdat_pull_o = 1'b0;
	endtask

	// ==================================================
	// host to device
	// ==================================================

	task automatic recv_host(output logic [10:0] frame);
		// request is clock released with the start bit already low
		while (!(kclk_i && !kdat_i)) @(negedge clk_i);
		wait_cycles(QUARTER_CYC);
		for (int i = 0; i < 11; i++) begin
			kclk_pull_o = 1'b1;
			wait_cycles(QUARTER_CYC);
			// host changed data after the last rise, settled by now
			frame[i] = kdat_i;
			wait_cycles(QUARTER_CYC);
			kclk_pull_o = 1'b0;
			wait_cycles(HALF_CYC);
		end
		// acknowledge is data low across one more pulse
		kdat_pull_o = 1'b1;
		wait_cycles(QUARTER_CYC);
		clock_pulse();
		wait_cycles(QUARTER_CYC);
		kdat_pull_o = 1'b0;
	endtask

endmodule

/* test/tb_ps2_host.sv */
`timescale 1ns/10ps

`include "ps2_defs.svh"

module tb_ps2_host;
	import ps2_pkg::*;

	typedef enum logic [2:0] {
		OP_RX_GOOD,
		OP_RX_BAD,
		OP_GLITCH,
		OP_TX,
		OP_ABORT,
		OP_CLEAR
	} op_e;

	// one stimulus row, rnd replaces val with a random byte
	typedef struct packed {
		op_e        op;
		logic       rnd;
		logic [7:0] val;
		logic [7:0] exp_status;
		logic [7:0] exp_data;
	} row_t;

	localparam int NUM_ROWS     = 12;
	localparam int RESET_CYCLES = 10;
	// eleven bits of 40 us
	localparam int FRAME_CYCLES = 11 * (`PS2_CLK_FREQ / 25000);
	localparam int LIMIT_CYCLES = NUM_ROWS * 2 * FRAME_CYCLES + RESET_CYCLES;
	localparam int POLL_LIMIT   = 1000;
	// abort lands in the 5 us wait after the start bit, clock still held
	localparam int ABORT_DELAY  = `PS2_CNT_100US + `PS2_CNT_5US / 2;

	logic         clk;
	logic         rst;
	ps2_bus_req_t req;
	logic [7:0]   rd_dat;
	logic         rd_ack;
	logic         irq;
	logic         kclk_en;
	logic         kdat_en;
	logic         dev_clk_pull;
	logic         dev_dat_pull;
	wire          kclk_line;
	wire          kdat_line;
	row_t         rows [NUM_ROWS];
	int           cycles;

	// open-collector lines, high unless someone pulls
	assign kclk_line = ~(kclk_en | dev_clk_pull);
	assign kdat_line = ~(kdat_en | dev_dat_pull);

	ps2_host i_ps2_host (
		.clk_i     (clk),
		.rst_i     (rst),
		.req_i     (req),
		.dat_o     (rd_dat),
		.ack_o     (rd_ack),
		.irq_o     (irq),
		.kclk_i    (kclk_line),
		.kdat_i    (kdat_line),
		.kclk_en_o (kclk_en),
		.kdat_en_o (kdat_en)
	);

	ps2_dev_model i_dev_model (
		.clk_i       (clk),
		.kclk_i      (kclk_line),
		.kdat_i      (kdat_line),
		.kclk_pull_o (dev_clk_pull),
		.kdat_pull_o (dev_dat_pull)
	);

	// 8 ns period
	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ==================================================
	// helpers
	// ==================================================

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic compare(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			stop_run($sformatf("[ERROR] %s: expected %0h, actual %0h", name, expected, actual));
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// request held for one cycle, response two rising edges later
	task automatic bus_access(input logic we, input ps2_reg_addr_e adr,
		input logic [7:0] wdat, output logic [7:0] rdat);
		req.cs  = 1'b1;
		req.we  = we;
		req.adr = adr;
		req.dat = wdat;
		@(negedge clk);
		req = '0;
		@(negedge clk);
		compare("bus acknowledge", 1, rd_ack);
		rdat = rd_dat;
	endtask

	task automatic write_reg(input ps2_reg_addr_e adr, input logic [7:0] wdat);
		logic [7:0] unused;
		bus_access(1'b1, adr, wdat, unused);
	endtask

	task automatic read_reg(input ps2_reg_addr_e adr, output logic [7:0] rdat);
		bus_access(1'b0, adr, 8'h00, rdat);
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		while (!irq && n < FRAME_CYCLES) begin
			@(negedge clk);
			n++;
		end
		if (!irq) begin
			stop_run("receive full never rose after a device frame");
		end
	endtask

	// poll status until transmit complete is back
	task automatic wait_tx_done();
		ps2_reg_word_u word;
		logic [7:0]    rdat;
		int            polls;
		polls = 0;
		read_reg(REG_STATUS, rdat);
		word.data = rdat;
		while (!word.status.tc && polls < POLL_LIMIT) begin
			read_reg(REG_STATUS, rdat);
			word.data = rdat;
			polls++;
		end
		if (!word.status.tc) begin
			stop_run("transmit complete never returned high");
		end
	endtask

	// ==================================================
	// stimulus table
	// ==================================================

	function automatic row_t make_row(input op_e op, input logic rnd, input logic [7:0] val,
		input logic [7:0] exp_status, input logic [7:0] exp_data);
		row_t r;
		r.op         = op;
		r.rnd        = rnd;
		r.val        = val;
		r.exp_status = exp_status;
		r.exp_data   = exp_data;
		return r;
	endfunction

	// status is full, tc, ack in bits 7 to 5 and parity error in bit 0
	task automatic fill_table();
		rows[0]  = make_row(OP_RX_GOOD, 1'b0, 8'hA5, 8'hC0, 8'hA5);
		rows[1]  = make_row(OP_CLEAR,   1'b0, 8'h00, 8'h40, 8'hFF);
		rows[2]  = make_row(OP_RX_BAD,  1'b0, 8'h3C, 8'hC1, 8'h3C);
		rows[3]  = make_row(OP_CLEAR,   1'b0, 8'h00, 8'h40, 8'hFF);
		// a glitch taken as a bit would misalign the frame of row 6
		rows[4]  = make_row(OP_GLITCH,  1'b0, 8'h00, 8'h40, 8'hFF);
		rows[5]  = make_row(OP_TX,      1'b0, 8'h5A, 8'h60, 8'h5A);
		rows[6]  = make_row(OP_RX_GOOD, 1'b0, 8'h96, 8'hE0, 8'h96);
		rows[7]  = make_row(OP_CLEAR,   1'b0, 8'h00, 8'h60, 8'hFF);
		// load clears the old acknowledge
		rows[8]  = make_row(OP_ABORT,   1'b0, 8'hC3, 8'h40, 8'hFF);
		rows[9]  = make_row(OP_TX,      1'b1, 8'h00, 8'h60, 8'h00);
		rows[10] = make_row(OP_RX_GOOD, 1'b1, 8'h00, 8'hE0, 8'h00);
		rows[11] = make_row(OP_CLEAR,   1'b0, 8'h00, 8'h60, 8'hFF);
	endtask

	task automatic apply_row(input int idx, input row_t row);
		logic [7:0]  val;
		logic [7:0]  exp_data;
		logic [7:0]  rdat;
		logic [10:0] frame;
		string       name;
		val      = row.rnd ? 8'($urandom % 256) : row.val;
		exp_data = row.rnd ? val : row.exp_data;
		name     = $sformatf("row %0d", idx);
		case (row.op)
			OP_RX_GOOD, OP_RX_BAD: begin
				i_dev_model.send_frame(val, row.op == OP_RX_BAD);
				wait_irq();
				// unread byte keeps the device off the line
				compare({name, " clock held low"}, 0, kclk_line);
			end
			OP_GLITCH: begin
				i_dev_model.send_glitch();
			end
			OP_TX: begin
				write_reg(REG_DATA, val);
				i_dev_model.recv_host(frame);
				compare({name, " start bit"}, 0, frame[0]);
				compare({name, " device byte"}, exp_data, frame[8:1]);
				// data and parity together hold an odd count of ones
				compare({name, " odd parity"}, 1, ^frame[9:1]);
				compare({name, " stop bit"}, 1, frame[10]);
				wait_tx_done();
			end
			OP_ABORT: begin
				write_reg(REG_DATA, val);
				wait_cycles(ABORT_DELAY);
				compare({name, " request clock hold"}, 1, kclk_en);
				compare({name, " start bit driven"}, 1, kdat_en);
				write_reg(REG_STATUS, 8'hFF);
			end
			default: begin
				write_reg(REG_STATUS, 8'h00);
			end
		endcase
		// interrupt and clock hold both follow receive full
		read_reg(REG_STATUS, rdat);
		compare({name, " status"}, row.exp_status, rdat);
		compare({name, " irq"}, row.exp_status[7], irq);
		compare({name, " clock enable"}, row.exp_status[7], kclk_en);
		compare({name, " data enable"}, 0, kdat_en);
		if (row.op != OP_TX) begin
			read_reg(REG_DATA, rdat);
			compare({name, " data"}, exp_data, rdat);
		end
	endtask

	// ==================================================
	// run
	// ==================================================

	// cycle budget covers every row twice over
	initial begin
		cycles = 0;
		while (cycles < LIMIT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		stop_run($sformatf("timeout after %0d cycles, a test never finished", LIMIT_CYCLES));
	end

	initial begin : run_tests
		logic [7:0]    rdat;
		ps2_reg_word_u word;
		void'($urandom(47));
		rst = 1'b1;
		req = '0;
		fill_table();
		wait_cycles(RESET_CYCLES);
		rst = 1'b0;
		@(negedge clk);
		// idle state after reset
		read_reg(REG_STATUS, rdat);
		word.data = rdat;
		compare("reset tc", 1, word.status.tc);
		compare("reset rx full", 0, word.status.rx_full);
		compare("reset parity error", 0, word.status.perr);
		compare("reset clock enable", 0, kclk_en);
		compare("reset data enable", 0, kdat_en);
		compare("reset irq", 0, irq);
		for (int i = 0; i < NUM_ROWS; i++) begin
			apply_row(i, rows[i]);
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* tb.f */
+incdir+rtl
rtl/ps2_pkg.sv
rtl/ps2_line_filter.sv
rtl/ps2_timer.sv
rtl/ps2_rx_frame.sv
rtl/ps2_tx_sequencer.sv
rtl/ps2_tx_shifter.sv
rtl/ps2_regs.sv
rtl/ps2_host.sv
test/ps2_dev_model.sv
test/tb_ps2_host.sv

/* Bender.yml */
package:
  name: ps2_host

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ps2_pkg.sv
      - rtl/ps2_line_filter.sv
      - rtl/ps2_timer.sv
      - rtl/ps2_rx_frame.sv
      - rtl/ps2_tx_sequencer.sv
      - rtl/ps2_tx_shifter.sv
      - rtl/ps2_regs.sv
      - rtl/ps2_host.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/ps2_dev_model.sv
      - test/tb_ps2_host.sv
